// ==== common/io_pkg.sv ====
package io_pkg;

	// --------------------------------------------------
	// Channel geometry
	// --------------------------------------------------

	localparam int nr_channels = 8;	// DIOB pins on the card
	localparam int mode_bits = 3;
	localparam int sel_bits = 4;	// Raw selector field per channel

	// Internal processing modes after the remap
	typedef enum logic [mode_bits-1:0] {
		mode_disable       = 3'd0,
		mode_pass_out      = 3'd1,
		mode_pass_in       = 3'd2,
		mode_debounce2     = 3'd3,
		mode_debounce4     = 3'd4,
		mode_long_debounce = 3'd5
	} proc_mode_t;

	// Raw selector codes as software writes them, 6 to 15 unknown
	localparam logic [sel_bits-1:0] sel_disable = 4'd0;
	localparam logic [sel_bits-1:0] sel_pass_out = 4'd1;
	localparam logic [sel_bits-1:0] sel_pass_in = 4'd2;
	localparam logic [sel_bits-1:0] sel_debounce2 = 4'd3;
	localparam logic [sel_bits-1:0] sel_debounce4 = 4'd4;
	localparam logic [sel_bits-1:0] sel_long_debounce = 4'd5;

	// --------------------------------------------------
	// Debounce lengths
	// --------------------------------------------------

	localparam int short_stages_a = 2;
	localparam int short_stages_b = 4;	// Also the depth of the sample history

	localparam int long_count_bits = 7;
	localparam logic [long_count_bits-1:0] long_ticks = 7'd125;	// Stable samples needed

endpackage

// ==== common/bus_pkg.sv ====
package bus_pkg;

	localparam int addr_bits = 8;
	localparam int data_bits = 16;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------

	// Version word, major in the upper byte
	localparam logic [addr_bits-1:0] addr_info = 8'd0;

	// Default flags in 7..0, their OR in bit 8
	localparam logic [addr_bits-1:0] addr_status = 8'd1;

	localparam logic [addr_bits-1:0] addr_gpio_out = 8'd2;	// Read and write
	localparam logic [addr_bits-1:0] addr_gpio_in = 8'd3;	// Processed inputs, read only

	// Selectors, 4 bits per channel, lowest channel in the lowest nibble
	localparam logic [addr_bits-1:0] addr_sel_low = 8'd4;	// Channels 0 to 3
	localparam logic [addr_bits-1:0] addr_sel_high = 8'd5;	// Channels 4 to 7

	localparam logic [7:0] version_major = 8'd1;
	localparam logic [7:0] version_minor = 8'd2;

	// --------------------------------------------------
	// Host bus
	// --------------------------------------------------

	// Triggers are single-cycle pulses, addr and data_w valid with them
	typedef struct packed {
		logic [addr_bits-1:0] addr;
		logic [data_bits-1:0] data_w;
		logic read_trg;
		logic write_trg;
	} bus_req_t;

	// dtack one cycle after any trigger; data_r only valid with dtack
	typedef struct packed {
		logic [data_bits-1:0] data_r;
		logic dtack;
	} bus_rsp_t;

endpackage

// ==== channel/long_debounce.sv ====
`timescale 1ns/1ps

module long_debounce (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic sample,
	output logic level
);

	// Length of the current run of equal samples, saturates at long_ticks
	logic [io_pkg::long_count_bits-1:0] count;
	logic last;	// Previous sample

	always_ff @(posedge clock)
	begin
		if (reset || !enable)
		begin
			count <= '0;
			last <= 1'b0;
			level <= 1'b0;
		end
		else
		begin
			last <= sample;

			if (count == '0 || sample != last)
			begin
				// First sample of a new run
				count <= {{(io_pkg::long_count_bits-1){1'b0}}, 1'b1};
			end
			else
			begin
				if (count != io_pkg::long_ticks)
					count <= count + 1'b1;

				// This sample completes the run or the run is already long enough
				if (count >= io_pkg::long_ticks - 1'b1)
					level <= sample;
			end
		end
	end

endmodule

// ==== channel/channel_proc.sv ====
`timescale 1ns/1ps

module channel_proc (
	input logic clock,
	input logic reset,
	input io_pkg::proc_mode_t mode,
	input logic sync_in,	// Already through the two-stage synchronizer
	input logic gpio_bit,
	output logic proc_in,
	output logic pin_out,
	output logic pin_oe
);

	// Last samples, newest at bit 0; with sync_in they form the window
	logic [io_pkg::short_stages_b-2:0] hist;
	logic [io_pkg::short_stages_b-1:0] win;

	logic deb_a;	// Level of the 2-sample debounce
	logic deb_b;	// Level of the 4-sample debounce
	logic long_level;
	logic long_en;
	logic pass_out;

	// New level once the newest n samples agree, otherwise keep the old one
	function automatic logic settle(
		input logic [io_pkg::short_stages_b-1:0] samples,
		input int n,
		input logic cur
	);
		logic [io_pkg::short_stages_b-1:0] mask;
		mask = {io_pkg::short_stages_b{1'b1}} >> (io_pkg::short_stages_b - n);
		if (&(samples | ~mask))
			return 1'b1;
		if (~|(samples & mask))
			return 1'b0;
		return cur;
	endfunction

	assign win = {hist, sync_in};
	assign long_en = (mode == io_pkg::mode_long_debounce);
	assign pass_out = (mode == io_pkg::mode_pass_out);

	long_debounce long_debounce_i (
		.clock  (clock),
		.reset  (reset),
		.enable (long_en),
		.sample (sync_in),
		.level  (long_level)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			hist <= '0;
			deb_a <= 1'b0;
			deb_b <= 1'b0;
			proc_in <= 1'b0;
			pin_out <= 1'b0;
			pin_oe <= 1'b0;
		end
		else
		begin
			hist <= win[io_pkg::short_stages_b-2:0];

			// A level outside its own mode is held at 0, so it restarts on entry
			deb_a <= (mode == io_pkg::mode_debounce2) ?
				settle(win, io_pkg::short_stages_a, deb_a) : 1'b0;
			deb_b <= (mode == io_pkg::mode_debounce4) ?
				settle(win, io_pkg::short_stages_b, deb_b) : 1'b0;

			case (mode)
				io_pkg::mode_pass_in:       proc_in <= sync_in;
				io_pkg::mode_debounce2:     proc_in <= deb_a;
				io_pkg::mode_debounce4:     proc_in <= deb_b;
				io_pkg::mode_long_debounce: proc_in <= long_level;
				default:                    proc_in <= 1'b0;	// Disable and pass out
			endcase

			// Pin is only driven in pass-out mode
			pin_out <= pass_out & gpio_bit;
			pin_oe <= pass_out;
		end
	end

endmodule

// ==== regs/blackbox_regs.sv ====
`timescale 1ns/1ps

module blackbox_regs (
	input logic clock,
	input logic reset,
	input bus_pkg::bus_req_t bus_req,
	output bus_pkg::bus_rsp_t bus_rsp,
	input logic [io_pkg::nr_channels-1:0] proc_in,
	output io_pkg::proc_mode_t mode [io_pkg::nr_channels-1:0],
	output logic [io_pkg::nr_channels-1:0] gpio_out
);

	// Raw selector per channel, two channels halves map to two bus words
	logic [io_pkg::nr_channels-1:0][io_pkg::sel_bits-1:0] sel;

	logic [io_pkg::nr_channels-1:0] default_sel;	// Unknown code per channel
	logic [bus_pkg::data_bits-1:0] rd_data;

	// --------------------------------------------------
	// Selector remap
	// --------------------------------------------------

	always_comb
	begin
		for (int i = 0; i < io_pkg::nr_channels; i++)
		begin
			default_sel[i] = 1'b0;
			case (sel[i])
				io_pkg::sel_disable:       mode[i] = io_pkg::mode_disable;
				io_pkg::sel_pass_out:      mode[i] = io_pkg::mode_pass_out;
				io_pkg::sel_pass_in:       mode[i] = io_pkg::mode_pass_in;
				io_pkg::sel_debounce2:     mode[i] = io_pkg::mode_debounce2;
				io_pkg::sel_debounce4:     mode[i] = io_pkg::mode_debounce4;
				io_pkg::sel_long_debounce: mode[i] = io_pkg::mode_long_debounce;
				default:
				begin
					mode[i] = io_pkg::mode_disable;	// Unknown code falls back to off
					default_sel[i] = 1'b1;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// Read multiplexer
	// --------------------------------------------------

	always_comb
	begin
		rd_data = '0;	// Unmapped addresses read as 0
		case (bus_req.addr)
			bus_pkg::addr_info:
				rd_data = {bus_pkg::version_major, bus_pkg::version_minor};
			bus_pkg::addr_status:
			begin
				rd_data[io_pkg::nr_channels-1:0] = default_sel;
				rd_data[io_pkg::nr_channels] = |default_sel;	// Any channel defaulted
			end
			bus_pkg::addr_gpio_out:
				rd_data[io_pkg::nr_channels-1:0] = gpio_out;
			bus_pkg::addr_gpio_in:
				rd_data[io_pkg::nr_channels-1:0] = proc_in;
			bus_pkg::addr_sel_low:
				rd_data = sel[3:0];
			bus_pkg::addr_sel_high:
				rd_data = sel[7:4];
			default:
				rd_data = '0;
		endcase
	end

	// --------------------------------------------------
	// Register writes and response
	// --------------------------------------------------

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sel <= '0;	// All channels disabled
			gpio_out <= '0;
		end
		else if (bus_req.write_trg)
		begin
			// Read-only and unmapped addresses fall through untouched
			case (bus_req.addr)
				bus_pkg::addr_gpio_out:
					gpio_out <= bus_req.data_w[io_pkg::nr_channels-1:0];
				bus_pkg::addr_sel_low:
					sel[3:0] <= bus_req.data_w;
				bus_pkg::addr_sel_high:
					sel[7:4] <= bus_req.data_w;
				default:
				begin
				end
			endcase
		end
	end

	// Every trigger is answered on the next cycle
	always_ff @(posedge clock)
	begin
		if (reset)
			bus_rsp <= '0;
		else
		begin
			bus_rsp.dtack <= bus_req.read_trg | bus_req.write_trg;
			bus_rsp.data_r <= bus_req.read_trg ? rd_data : '0;
		end
	end

endmodule

// ==== source/io_blackbox.sv ====
`timescale 1ns/1ps

module io_blackbox (
	input logic clock,
	input logic reset,
	input bus_pkg::bus_req_t bus_req,
	output bus_pkg::bus_rsp_t bus_rsp,
	input logic [io_pkg::nr_channels-1:0] diob_in,	// Raw pad inputs, asynchronous
	output logic [io_pkg::nr_channels-1:0] diob_out,
	output logic [io_pkg::nr_channels-1:0] diob_oe	// Pad driver enables
);

	// --------------------------------------------------
	// Input synchronizer
	// --------------------------------------------------

	logic [io_pkg::nr_channels-1:0] sync_meta;	// First stage, may go metastable
	logic [io_pkg::nr_channels-1:0] sync_in;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sync_meta <= '0;
			sync_in <= '0;
		end
		else
		begin
			sync_meta <= diob_in;
			sync_in <= sync_meta;
		end
	end

	// --------------------------------------------------
	// Register block
	// --------------------------------------------------

	io_pkg::proc_mode_t mode [io_pkg::nr_channels-1:0];
	logic [io_pkg::nr_channels-1:0] gpio_out;
	logic [io_pkg::nr_channels-1:0] proc_in;	// Processed inputs for readback

	blackbox_regs blackbox_regs_i (
		.clock    (clock),
		.reset    (reset),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp),
		.proc_in  (proc_in),
		.mode     (mode),
		.gpio_out (gpio_out)
	);

	// --------------------------------------------------
	// Channel array
	// --------------------------------------------------

	// One processing stage per DIOB pin
	for (genvar i = 0; i < io_pkg::nr_channels; i++)
	begin : gen_chan
		channel_proc channel_proc_i (
			.clock    (clock),
			.reset    (reset),
			.mode     (mode[i]),
			.sync_in  (sync_in[i]),
			.gpio_bit (gpio_out[i]),
			.proc_in  (proc_in[i]),
			.pin_out  (diob_out[i]),
			.pin_oe   (diob_oe[i])
		);
	end

endmodule

// ==== tb/tb_io_blackbox.sv ====
`timescale 1ns/1ps

module tb_io_blackbox;

	localparam int clock_period = 100;
	localparam int reset_cycles = 10;
	// Twice the roughly 360 cycles of all tests, long debounce the largest part
	localparam int max_cycles = 720;

	logic clock;
	logic reset;
	bus_pkg::bus_req_t bus_req;
	bus_pkg::bus_rsp_t bus_rsp;
	logic [7:0] diob_in;
	logic [7:0] diob_out;
	logic [7:0] diob_oe;

	int errors;	// Wrong values
	int bus_errors;	// Missing or late dtack
	int cycles;
	logic [31:0] seed;

	io_blackbox dut_i (
		.clock    (clock),
		.reset    (reset),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp),
		.diob_in  (diob_in),
		.diob_out (diob_out),
		.diob_oe  (diob_oe)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("Run stopped after %0d cycles, the tests did not finish in time", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		seed = xorshift(seed);
		return seed;
	endfunction

	task automatic report_mismatch(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		errors++;
		$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clock);
	endtask

	// One host access that returns on the falling edge where dtack is expected
	task automatic bus_access(input logic is_write, input logic [7:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata);
		int waited;
		@(negedge clock);
		bus_req.addr = addr;
		bus_req.data_w = wdata;
		bus_req.read_trg = ~is_write;
		bus_req.write_trg = is_write;
		@(negedge clock);
		bus_req.read_trg = 1'b0;	// Trigger is a single-cycle pulse
		bus_req.write_trg = 1'b0;
		waited = 1;
		while (!bus_rsp.dtack && waited < 4)
		begin
			@(negedge clock);
			waited++;
		end
		rdata = bus_rsp.data_r;
		if (!bus_rsp.dtack)
		begin
			bus_errors++;
			$display("No dtack at %0t ns for the access to address %0d", $time, addr);
		end
		else if (waited != 1)
		begin
			bus_errors++;
			$display("dtack came %0d cycles after the trigger to address %0d instead of 1",
				waited, addr);
		end
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
		logic [15:0] unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [15:0] data);
		bus_access(1'b0, addr, 16'h0000, data);
	endtask

	// Same raw selector code on all eight channels
	task automatic set_all_modes(input logic [3:0] code);
		bus_write(bus_pkg::addr_sel_low, {4{code}});
		bus_write(bus_pkg::addr_sel_high, {4{code}});
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------

	task automatic check_after_reset();
		logic [15:0] rdata;
		bus_read(bus_pkg::addr_info, rdata);
		if (rdata !== 16'h0102)
			report_mismatch("info word", rdata, 16'h0102);
		bus_read(bus_pkg::addr_status, rdata);
		if (rdata !== 16'h0000)
			report_mismatch("status after reset", rdata, 16'h0000);
		if (diob_oe !== 8'h00)
			report_mismatch("diob_oe after reset", {8'h00, diob_oe}, 16'h0000);
		if (diob_out !== 8'h00)
			report_mismatch("diob_out after reset", {8'h00, diob_out}, 16'h0000);
	endtask

	task automatic drive_pass_out();
		logic [31:0] r;
		logic [15:0] rdata;
		logic [7:0] pattern;
		logic [7:0] prev;
		prev = 8'h00;
		set_all_modes(4'd1);
		repeat (4)
		begin
			r = next_random();
			pattern = r[7:0];
			bus_write(bus_pkg::addr_gpio_out, {8'h00, pattern});
			if (diob_out !== prev)	// Pin register still one cycle behind
				report_mismatch("diob_out before update", {8'h00, diob_out}, {8'h00, prev});
			wait_cycles(1);
			if (diob_out !== pattern)
				report_mismatch("diob_out", {8'h00, diob_out}, {8'h00, pattern});
			if (diob_oe !== 8'hff)
				report_mismatch("diob_oe in pass out", {8'h00, diob_oe}, 16'h00ff);
			bus_read(bus_pkg::addr_gpio_out, rdata);
			if (rdata !== {8'h00, pattern})
				report_mismatch("gpio_out readback", rdata, {8'h00, pattern});
			prev = pattern;
		end
	endtask

	task automatic read_pass_in();
		logic [31:0] r;
		logic [15:0] rdata;
		logic [7:0] pattern;
		set_all_modes(4'd2);
		repeat (4)
		begin
			r = next_random();
			pattern = r[7:0];
			diob_in = pattern;
			wait_cycles(3);	// Synchronizer and output register
			bus_read(bus_pkg::addr_gpio_in, rdata);
			if (rdata !== {8'h00, pattern})
				report_mismatch("pass in", rdata, {8'h00, pattern});
		end
		// Upper four channels off
		bus_write(bus_pkg::addr_sel_high, 16'h0000);
		r = next_random();
		pattern = r[7:0];
		diob_in = pattern;
		wait_cycles(3);
		bus_read(bus_pkg::addr_gpio_in, rdata);
		if (rdata !== {12'h000, pattern[3:0]})
			report_mismatch("pass in with disabled half", rdata, {12'h000, pattern[3:0]});
	endtask

	task automatic filter_glitches(input logic [3:0] code, input int stages);
		logic [31:0] r;
		logic [15:0] rdata;
		logic [7:0] pattern;
		diob_in = 8'h00;
		set_all_modes(code);
		wait_cycles(stages + 4);
		bus_read(bus_pkg::addr_gpio_in, rdata);
		if (rdata !== 16'h0000)
			report_mismatch("debounce start level", rdata, 16'h0000);
		r = next_random();
		pattern = r[7:0] | 8'h01;

		// One-cycle high glitch
		diob_in = pattern;
		wait_cycles(1);
		diob_in = 8'h00;
		repeat (stages + 3)
		begin
			bus_read(bus_pkg::addr_gpio_in, rdata);
			if (rdata !== 16'h0000)
				report_mismatch("high glitch passed", rdata, 16'h0000);
		end

		diob_in = pattern;
		wait_cycles(stages + 4);	// Longer than N+3
		bus_read(bus_pkg::addr_gpio_in, rdata);
		if (rdata !== {8'h00, pattern})
			report_mismatch("debounced level", rdata, {8'h00, pattern});

		// One-cycle low glitch
		diob_in = 8'h00;
		wait_cycles(1);
		diob_in = pattern;
		repeat (stages + 3)
		begin
			bus_read(bus_pkg::addr_gpio_in, rdata);
			if (rdata !== {8'h00, pattern})
				report_mismatch("low glitch passed", rdata, {8'h00, pattern});
		end
	endtask

	task automatic hold_long_level();
		logic [31:0] r;
		logic [15:0] rdata;
		logic [7:0] pattern;
		diob_in = 8'h00;
		set_all_modes(4'd5);
		r = next_random();
		pattern = r[7:0] | 8'h01;
		diob_in = pattern;
		wait_cycles(100);
		bus_read(bus_pkg::addr_gpio_in, rdata);	// Sampled after 100 cycles
		if (rdata !== 16'h0000)
			report_mismatch("long debounce too early", rdata, 16'h0000);
		wait_cycles(29);
		bus_read(bus_pkg::addr_gpio_in, rdata);	// About 130 cycles
		if (rdata !== {8'h00, pattern})
			report_mismatch("long debounce level", rdata, {8'h00, pattern});
	endtask

	task automatic decode_unknown_selectors();
		logic [31:0] r;
		logic [15:0] rdata;
		logic [3:0] code;
		logic [7:0] flags;
		logic [7:0] oe_exp;
		logic [7:0] in_exp;
		logic [7:0] in_care;	// Long debounce channels left out
		diob_in = 8'hff;
		// Every pin that is driven goes high
		bus_write(bus_pkg::addr_gpio_out, 16'h00ff);
		repeat (3)
		begin
			r = next_random();
			for (int i = 0; i < 8; i++)
			begin
				code = r[4 * i +: 4];
				flags[i] = (code > 4'd5);
				oe_exp[i] = (code == 4'd1);
				in_exp[i] = (code == 4'd2) || (code == 4'd3) || (code == 4'd4);
				in_care[i] = (code != 4'd5);
			end
			bus_write(bus_pkg::addr_sel_low, r[15:0]);
			bus_write(bus_pkg::addr_sel_high, r[31:16]);
			bus_read(bus_pkg::addr_status, rdata);
			if (rdata !== {7'h00, |flags, flags})
				report_mismatch("status flags", rdata, {7'h00, |flags, flags});
			wait_cycles(10);
			if (diob_oe !== oe_exp)
				report_mismatch("diob_oe per mode", {8'h00, diob_oe}, {8'h00, oe_exp});
			if (diob_out !== oe_exp)	// Only pass-out channels drive the high level
				report_mismatch("diob_out per mode", {8'h00, diob_out}, {8'h00, oe_exp});
			bus_read(bus_pkg::addr_gpio_in, rdata);
			if ({rdata[15:8], rdata[7:0] & in_care} !== {8'h00, in_exp})
				report_mismatch("inputs per mode", rdata, {8'h00, in_exp});
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial
	begin
		errors = 0;
		bus_errors = 0;
		cycles = 0;
		seed = 32'd85777;
		reset = 1'b1;
		bus_req = '0;
		diob_in = 8'h00;
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;

		check_after_reset();
		drive_pass_out();
		read_pass_in();
		filter_glitches(4'd3, 2);
		filter_glitches(4'd4, 4);
		hold_long_level();
		decode_unknown_selectors();

		$display("Value errors: %0d, bus handshake errors: %0d", errors, bus_errors);
		if (errors == 0 && bus_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
common/io_pkg.sv
common/bus_pkg.sv
channel/long_debounce.sv
channel/channel_proc.sv
regs/blackbox_regs.sv
source/io_blackbox.sv
tb/tb_io_blackbox.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module tb_io_blackbox -o sim_tb
	obj_dir/sim_tb | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
